// ==== bench/mempool_cc_props.sv ====
/*
  Handshake properties: valid and payload held under back-pressure,
  valid outputs quiet while reset is high
*/
`timescale 1ns/1ps

module mempool_cc_props #(
  parameter int Width = 1
) (
  input logic             clk_i,
  input logic             rst_i,
  input logic             valid_i,
  input logic             ready_i,
  input logic [Width-1:0] data_i,
  input logic [1:0]       idle_i
);

  // A stalled transfer keeps its valid and its payload
  hold_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i && !ready_i |=> valid_i)
    else $error("valid dropped before its transfer");

  hold_data: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i && !ready_i |=> $stable(data_i))
    else $error("payload changed before its transfer");

  // Valid outputs stay low in reset
  quiet_in_reset: assert property (@(posedge clk_i) rst_i |-> (idle_i == 2'b00))
    else $error("valid output high during reset");

endmodule

// ==== bench/mempool_cc_tb.sv ====
/*
  Testbench of the core complex: clock and reset, instruction and TCDM
  responders, architectural reference model and checks
*/
`timescale 1ns/1ps
`include "mempool_cc_consts.svh"

module mempool_cc_tb;

  localparam int NUM_INSTR  = 400;
  localparam int CLK_PERIOD = 4;

  logic                 clk_i, rst_i;
  logic [`MCC_XLEN-1:0] inst_addr_o, data_qaddr_o, data_qdata_o, data_pdata_i;
  logic [31:0]          inst_data_i;
  logic                 inst_valid_o, inst_ready_i, data_qwrite_o, data_qvalid_o;
  logic                 data_qready_i, data_pvalid_i, data_pready_o;

  integer      seed;
  int          fetched;
  logic [31:0] prog  [0:NUM_INSTR-1];
  logic [31:0] dmem  [0:255];
  logic [31:0] mmem  [0:255];
  logic [31:0] mregs [0:31];
  logic [64:0] exp_q [$];
  logic [4:0]  last_rd;
  logic        rsp_pend;
  logic [1:0]  rsp_wait;
  logic [31:0] rsp_data;

  mempool_cc u_dut (
    .clk_i, .rst_i, .inst_addr_o, .inst_data_i, .inst_valid_o, .inst_ready_i,
    .data_qaddr_o, .data_qwrite_o, .data_qdata_o, .data_qvalid_o, .data_qready_i,
    .data_pdata_i, .data_pvalid_i, .data_pready_o
  );

  bind mempool_spill_register mempool_cc_props #(.Width(Width)) u_spill_props (
    .clk_i, .rst_i, .valid_i (valid_o), .ready_i (ready_i), .data_i (data_o),
    .idle_i ({valid_o, 1'b0})
  );
  bind mempool_cc mempool_cc_props #(.Width(`MCC_XLEN)) u_inst_props (
    .clk_i, .rst_i, .valid_i (inst_valid_o), .ready_i (inst_ready_i), .data_i (inst_addr_o),
    .idle_i ({inst_valid_o, data_qvalid_o})
  );
  bind mempool_cc mempool_cc_props #(.Width(2 * `MCC_XLEN + 1)) u_tcdm_props (
    .clk_i, .rst_i, .valid_i (data_qvalid_o), .ready_i (data_qready_i),
    .data_i ({data_qaddr_o, data_qwrite_o, data_qdata_o}), .idle_i ({data_qvalid_o, 1'b0})
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    sext12 = {{20{imm[11]}}, imm};
  endfunction

  // Instruction memory contents, zero past the program
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    if (addr < 32'(4 * NUM_INSTR)) begin
      word_at = prog[int'(addr[31:2])];
    end else begin
      word_at = 32'h0;
    end
  endfunction

  function automatic logic [31:0] dut_reg(input logic [4:0] r);
    dut_reg = u_dut.u_regfile.regs_q[r];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check(input logic [31:0] expected, input logic [31:0] actual, input string what);
    if (expected !== actual) begin
      abort_run($sformatf("mismatch at %0t ns: %s, expected %h, got %h",
                          $time, what, expected, actual));
    end
  endtask

  // --------------------
  // Program generator
  // --------------------
  task automatic build_program();
    int          n, kind;
    logic [31:0] r, r2, base, off;
    logic [4:0]  rd, rs1, rs2, rb;
    logic [2:0]  f3;
    n = 0;
    while (n < NUM_INSTR) begin
      r    = next_rand();
      r2   = next_rand();
      kind = int'(r2 % 32'd100);
      rd   = {2'b00, r[2:0]};
      rs1  = {2'b00, r[5:3]};
      rs2  = {2'b00, r[8:6]};
      rb   = (r[11:9] == 3'd0) ? 5'd1 : {2'b00, r[11:9]};
      base = {23'd0, r[18:12], 2'b00};
      off  = {23'd0, r[25:19], 2'b00};
      case (r[13:12])
        2'd0:    f3 = 3'b000;
        2'd1:    f3 = 3'b011;
        2'd2:    f3 = 3'b101;
        default: f3 = 3'b111;
      endcase
      if (kind < 5) begin
        prog[n] = {r[31:7], 7'b1011011};
      end else if (kind < 60 && kind >= 35) begin
        prog[n] = {7'b0000001, rs2, rs1, f3, rd, `MCC_OPC_OP};
      end else if (kind >= 60 && n <= NUM_INSTR - 2) begin
        // Base register first, then a word access inside the data array
        prog[n] = {base[11:0], 5'd0, 3'b000, rb, `MCC_OPC_OPIMM};
        n = n + 1;
        if (r[26]) begin
          prog[n] = {off[11:0], rb, 3'b010, rd, `MCC_OPC_LOAD};
        end else begin
          prog[n] = {off[11:5], rs2, rb, 3'b010, off[4:0], `MCC_OPC_STORE};
        end
      end else begin
        prog[n] = {r2[31:20], rs1, 3'b000, rd, `MCC_OPC_OPIMM};
      end
      n = n + 1;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  task automatic write_model_reg(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
      mregs[rd] = value;
      last_rd   = rd;
    end
  endtask

  task automatic model_step(input logic [31:0] w);
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [31:0] a, b, addr;
    logic [63:0] prod;
    rd      = w[11:7];
    rs1     = w[19:15];
    rs2     = w[24:20];
    f3      = w[14:12];
    a       = mregs[rs1];
    b       = mregs[rs2];
    prod    = {32'd0, a} * {32'd0, b};
    last_rd = 5'd0;
    if (w[6:0] == `MCC_OPC_OPIMM && f3 == 3'b000) begin
      write_model_reg(rd, a + sext12(w[31:20]));
    end else if (w[6:0] == `MCC_OPC_LOAD && f3 == 3'b010) begin
      addr = a + sext12(w[31:20]);
      exp_q.push_back({1'b0, addr, 32'd0});
      write_model_reg(rd, mmem[addr[9:2]]);
    end else if (w[6:0] == `MCC_OPC_STORE && f3 == 3'b010) begin
      addr = a + sext12({w[31:25], w[11:7]});
      exp_q.push_back({1'b1, addr, b});
      mmem[addr[9:2]] = b;
    end else if (w[6:0] == `MCC_OPC_OP && w[31:25] == 7'b0000001) begin
      case (f3)
        3'b000:  write_model_reg(rd, prod[31:0]);
        3'b011:  write_model_reg(rd, prod[63:32]);
        3'b101:  write_model_reg(rd, (b == 32'd0) ? 32'hffffffff : a / b);
        3'b111:  write_model_reg(rd, (b == 32'd0) ? a : a % b);
        default: ;
      endcase
    end
  endtask

  task automatic check_last_dest();
    if (last_rd != 5'd0) begin
      check(mregs[last_rd], dut_reg(last_rd), $sformatf("x%0d after writeback", last_rd));
    end
  endtask

  // --------------------
  // Memory responders
  // --------------------
  task automatic serve_tcdm_request();
    logic [64:0] want;
    logic [31:0] r;
    logic [7:0]  idx;
    if (exp_q.size() == 0) begin
      abort_run("TCDM request issued with no memory instruction outstanding");
    end else begin
      want = exp_q.pop_front();
      check({31'd0, want[64]}, {31'd0, data_qwrite_o}, "TCDM write flag");
      check(want[63:32], data_qaddr_o, "TCDM address");
      if (want[64]) begin
        check(want[31:0], data_qdata_o, "store data");
      end
      idx = data_qaddr_o[9:2];
      if (want[64]) begin
        dmem[idx] = data_qdata_o;
        rsp_data  = 32'd0;
      end else begin
        rsp_data = dmem[idx];
      end
      r        = next_rand();
      rsp_pend = 1'b1;
      rsp_wait = r[1:0];
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r             = next_rand();
    inst_ready_i  = r[0] && (fetched < NUM_INSTR);
    inst_data_i   = word_at(inst_addr_o);
    data_qready_i = r[1];
    if (rsp_pend && rsp_wait == 2'd0) begin
      data_pvalid_i = 1'b1;
      data_pdata_i  = rsp_data;
    end else begin
      data_pvalid_i = 1'b0;
      if (rsp_pend) begin
        rsp_wait = rsp_wait - 2'd1;
      end
    end
  endtask

  // Sample at the edge, drive 1 ns later
  always @(posedge clk_i) begin
    if (!rst_i) begin
      // TCDM responses are always accepted
      check(32'd1, {31'd0, data_pready_o}, "TCDM response ready");
      if (inst_valid_o && inst_ready_i) begin
        check(4 * fetched, inst_addr_o, "fetch address");
        check_last_dest();
        model_step(prog[fetched]);
        fetched = fetched + 1;
      end
      if (data_pvalid_i && data_pready_o) begin
        rsp_pend = 1'b0;
      end
      if (data_qvalid_o && data_qready_i) begin
        serve_tcdm_request();
      end
    end
    #1;
    drive_inputs();
  end

  initial begin
    #(NUM_INSTR * 40 * CLK_PERIOD);
    abort_run("Run hung: the program did not finish before the watchdog expired");
  end

  initial begin
    seed          = 32'h89377664;
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    inst_ready_i  = 1'b0;
    inst_data_i   = 32'd0;
    data_qready_i = 1'b0;
    data_pdata_i  = 32'd0;
    data_pvalid_i = 1'b0;
    fetched       = 0;
    last_rd       = 5'd0;
    rsp_pend      = 1'b0;
    rsp_wait      = 2'd0;
    rsp_data      = 32'd0;
    build_program();
    for (int i = 0; i < 256; i++) begin
      dmem[i] = next_rand();
      mmem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      mregs[i] = 32'd0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    check(32'd0, {30'd0, inst_valid_o, data_qvalid_o}, "valid outputs during reset");
    rst_i = 1'b0;
    // Last instruction is done once the next fetch is pending
    while (!((fetched == NUM_INSTR) && inst_valid_o)) begin
      @(negedge clk_i);
    end
    check_last_dest();
    for (int i = 1; i < 8; i++) begin
      check(mregs[i], dut_reg(5'(i)), $sformatf("final x%0d", i));
    end
    if (exp_q.size() != 0) begin
      abort_run("Memory instructions retired without their TCDM requests");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// ==== include/mempool_cc_consts.svh ====
/*
  Build-time constants of the core complex: data and offload id widths,
  cut register choices and the RV32 major opcodes in use
*/
`ifndef MEMPOOL_CC_CONSTS_SVH
`define MEMPOOL_CC_CONSTS_SVH

`define MCC_XLEN 32
`define MCC_ID_W 5

// 1 inserts the cut, 0 bypasses it
`define MCC_CUT_ACC_REQ  1
`define MCC_CUT_ACC_RSP  1
`define MCC_CUT_TCDM_REQ 0
`define MCC_CUT_TCDM_RSP 0

`define MCC_OPC_OP    7'b0110011
`define MCC_OPC_OPIMM 7'b0010011
`define MCC_OPC_LOAD  7'b0000011
`define MCC_OPC_STORE 7'b0100011

`endif

// ==== rtl/mempool_cc.sv ====
/*
  Core complex top: controller, register file, IPU and the four cuts
*/
`timescale 1ns/1ps
`include "mempool_cc_consts.svh"

module mempool_cc (
  input  logic                 clk_i,
  input  logic                 rst_i,
  output logic [`MCC_XLEN-1:0] inst_addr_o,
  input  logic [31:0]          inst_data_i,
  output logic                 inst_valid_o,
  input  logic                 inst_ready_i,
  output logic [`MCC_XLEN-1:0] data_qaddr_o,
  output logic                 data_qwrite_o,
  output logic [`MCC_XLEN-1:0] data_qdata_o,
  output logic                 data_qvalid_o,
  input  logic                 data_qready_i,
  input  logic [`MCC_XLEN-1:0] data_pdata_i,
  input  logic                 data_pvalid_i,
  output logic                 data_pready_o
);

  localparam int AccReqW  = 2 + `MCC_ID_W + 2 * `MCC_XLEN;
  localparam int AccRspW  = `MCC_XLEN + `MCC_ID_W;
  localparam int TcdmReqW = 2 * `MCC_XLEN + 1;

  logic [4:0]              rf_raddr_a, rf_raddr_b, rf_waddr;
  logic [`MCC_XLEN-1:0]    rf_rdata_a, rf_rdata_b, rf_wdata;
  logic                    rf_we;

  // Controller side of the offload channel
  mempool_cc_pkg::ipu_op_e ctrl_qop;
  logic [`MCC_ID_W-1:0]    ctrl_qid, ctrl_pid;
  logic [`MCC_XLEN-1:0]    ctrl_qarga, ctrl_qargb, ctrl_pdata;
  logic                    ctrl_qvalid, ctrl_qready, ctrl_pvalid, ctrl_pready;
  logic [AccRspW-1:0]      acc_rsp_q;

  // IPU side
  logic [AccReqW-1:0]      acc_req_q;
  logic [`MCC_ID_W-1:0]    ipu_pid;
  logic [`MCC_XLEN-1:0]    ipu_pdata;
  logic                    ipu_qvalid, ipu_qready, ipu_pvalid, ipu_pready;

  // TCDM channel, controller side
  logic [`MCC_XLEN-1:0]    tcdm_qaddr, tcdm_qdata, tcdm_pdata;
  logic                    tcdm_qwrite, tcdm_qvalid, tcdm_qready, tcdm_pvalid, tcdm_pready;
  logic [TcdmReqW-1:0]     tcdm_req_q;

  mempool_core_ctrl u_ctrl (
    .clk_i, .rst_i, .inst_addr_o, .inst_data_i, .inst_valid_o, .inst_ready_i,
    .rf_raddr_a_o  (rf_raddr_a),  .rf_raddr_b_o  (rf_raddr_b),
    .rf_rdata_a_i  (rf_rdata_a),  .rf_rdata_b_i  (rf_rdata_b),
    .rf_waddr_o    (rf_waddr),    .rf_wdata_o    (rf_wdata),    .rf_we_o (rf_we),
    .acc_qop_o     (ctrl_qop),    .acc_qid_o     (ctrl_qid),
    .acc_qarga_o   (ctrl_qarga),  .acc_qargb_o   (ctrl_qargb),
    .acc_qvalid_o  (ctrl_qvalid), .acc_qready_i  (ctrl_qready),
    .acc_pdata_i   (ctrl_pdata),  .acc_pid_i     (ctrl_pid),
    .acc_pvalid_i  (ctrl_pvalid), .acc_pready_o  (ctrl_pready),
    .data_qaddr_o  (tcdm_qaddr),  .data_qwrite_o (tcdm_qwrite), .data_qdata_o (tcdm_qdata),
    .data_qvalid_o (tcdm_qvalid), .data_qready_i (tcdm_qready),
    .data_pdata_i  (tcdm_pdata),  .data_pvalid_i (tcdm_pvalid), .data_pready_o (tcdm_pready)
  );

  mempool_regfile u_regfile (
    .clk_i, .rst_i,
    .raddr_a_i (rf_raddr_a), .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a), .rdata_b_o (rf_rdata_b),
    .waddr_i   (rf_waddr),   .wdata_i   (rf_wdata),   .we_i (rf_we)
  );

  // --------------------
  // Offload path
  // --------------------
  mempool_spill_register #(.Bypass(`MCC_CUT_ACC_REQ == 0), .Width(AccReqW)) u_cut_acc_req (
    .clk_i, .rst_i,
    .valid_i (ctrl_qvalid), .ready_o (ctrl_qready),
    .data_i  ({ctrl_qop, ctrl_qid, ctrl_qarga, ctrl_qargb}),
    .valid_o (ipu_qvalid),  .ready_i (ipu_qready), .data_o (acc_req_q)
  );

  mempool_ipu u_ipu (
    .clk_i, .rst_i,
    .qop_i    (mempool_cc_pkg::ipu_op_e'(acc_req_q[AccReqW-1 -: 2])),
    .qid_i    (acc_req_q[2*`MCC_XLEN +: `MCC_ID_W]),
    .qarga_i  (acc_req_q[`MCC_XLEN +: `MCC_XLEN]),
    .qargb_i  (acc_req_q[0 +: `MCC_XLEN]),
    .qvalid_i (ipu_qvalid), .qready_o (ipu_qready),
    .pdata_o  (ipu_pdata),  .pid_o    (ipu_pid),
    .pvalid_o (ipu_pvalid), .pready_i (ipu_pready)
  );

  mempool_spill_register #(.Bypass(`MCC_CUT_ACC_RSP == 0), .Width(AccRspW)) u_cut_acc_rsp (
    .clk_i, .rst_i,
    .valid_i (ipu_pvalid),  .ready_o (ipu_pready), .data_i ({ipu_pdata, ipu_pid}),
    .valid_o (ctrl_pvalid), .ready_i (ctrl_pready), .data_o (acc_rsp_q)
  );

  assign ctrl_pdata = acc_rsp_q[AccRspW-1 -: `MCC_XLEN];
  assign ctrl_pid   = acc_rsp_q[0 +: `MCC_ID_W];

  // --------------------
  // TCDM path
  // --------------------
  mempool_spill_register #(.Bypass(`MCC_CUT_TCDM_REQ == 0), .Width(TcdmReqW)) u_cut_tcdm_req (
    .clk_i, .rst_i,
    .valid_i (tcdm_qvalid),   .ready_o (tcdm_qready),
    .data_i  ({tcdm_qaddr, tcdm_qwrite, tcdm_qdata}),
    .valid_o (data_qvalid_o), .ready_i (data_qready_i), .data_o (tcdm_req_q)
  );

  assign data_qaddr_o  = tcdm_req_q[TcdmReqW-1 -: `MCC_XLEN];
  assign data_qwrite_o = tcdm_req_q[`MCC_XLEN];
  assign data_qdata_o  = tcdm_req_q[0 +: `MCC_XLEN];

  mempool_spill_register #(.Bypass(`MCC_CUT_TCDM_RSP == 0), .Width(`MCC_XLEN)) u_cut_tcdm_rsp (
    .clk_i, .rst_i,
    .valid_i (data_pvalid_i), .ready_o (data_pready_o), .data_i (data_pdata_i),
    .valid_o (tcdm_pvalid),   .ready_i (tcdm_pready),   .data_o (tcdm_pdata)
  );

endmodule

// ==== rtl/mempool_cc_pkg.sv ====
/*
  Types of the core complex: instruction word formats, the instruction
  union and the offload opcode enum
*/
package mempool_cc_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  // One fetched word, seen through each format
  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    s_type_t s_type;
  } instr_t;

  typedef enum logic [1:0] {
    MUL   = 2'd0,
    MULHU = 2'd1,
    DIVU  = 2'd2,
    REMU  = 2'd3
  } ipu_op_e;

endpackage

// ==== rtl/mempool_core_ctrl.sv ====
/*
  Core controller: fetch, decode, issue of offloads and TCDM requests,
  and register writeback
*/
`timescale 1ns/1ps
`include "mempool_cc_consts.svh"

module mempool_core_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  output logic [`MCC_XLEN-1:0]    inst_addr_o,
  input  logic [31:0]             inst_data_i,
  output logic                    inst_valid_o,
  input  logic                    inst_ready_i,
  output logic [4:0]              rf_raddr_a_o,
  output logic [4:0]              rf_raddr_b_o,
  input  logic [`MCC_XLEN-1:0]    rf_rdata_a_i,
  input  logic [`MCC_XLEN-1:0]    rf_rdata_b_i,
  output logic [4:0]              rf_waddr_o,
  output logic [`MCC_XLEN-1:0]    rf_wdata_o,
  output logic                    rf_we_o,
  output mempool_cc_pkg::ipu_op_e acc_qop_o,
  output logic [`MCC_ID_W-1:0]    acc_qid_o,
  output logic [`MCC_XLEN-1:0]    acc_qarga_o,
  output logic [`MCC_XLEN-1:0]    acc_qargb_o,
  output logic                    acc_qvalid_o,
  input  logic                    acc_qready_i,
  input  logic [`MCC_XLEN-1:0]    acc_pdata_i,
  input  logic [`MCC_ID_W-1:0]    acc_pid_i,
  input  logic                    acc_pvalid_i,
  output logic                    acc_pready_o,
  output logic [`MCC_XLEN-1:0]    data_qaddr_o,
  output logic                    data_qwrite_o,
  output logic [`MCC_XLEN-1:0]    data_qdata_o,
  output logic                    data_qvalid_o,
  input  logic                    data_qready_i,
  input  logic [`MCC_XLEN-1:0]    data_pdata_i,
  input  logic                    data_pvalid_i,
  output logic                    data_pready_o
);

  localparam logic [2:0] StIdle     = 3'd0;
  localparam logic [2:0] StFetch    = 3'd1;
  localparam logic [2:0] StDecode   = 3'd2;
  localparam logic [2:0] StExec     = 3'd3;
  localparam logic [2:0] StWaitAcc  = 3'd4;
  localparam logic [2:0] StWaitTcdm = 3'd5;

  logic [2:0]             state_q, state_d;
  logic [`MCC_XLEN-1:0]   pc_q, imm_i, imm_s, addi_sum;
  mempool_cc_pkg::instr_t instr_q;
  logic                   req_done_q, is_addi, is_load, is_store, is_mdu;

  // --------------------
  // Decode
  // --------------------
  assign imm_i = {{(`MCC_XLEN-12){instr_q.i_type.imm[11]}}, instr_q.i_type.imm};
  assign imm_s = {{(`MCC_XLEN-12){instr_q.s_type.imm_hi[6]}},
                  instr_q.s_type.imm_hi, instr_q.s_type.imm_lo};

  assign is_addi  = (instr_q.i_type.opcode == `MCC_OPC_OPIMM) && (instr_q.i_type.funct3 == 3'b000);
  assign is_load  = (instr_q.i_type.opcode == `MCC_OPC_LOAD) && (instr_q.i_type.funct3 == 3'b010);
  assign is_store = (instr_q.s_type.opcode == `MCC_OPC_STORE) && (instr_q.s_type.funct3 == 3'b010);
  assign is_mdu   = (instr_q.r_type.opcode == `MCC_OPC_OP) && (instr_q.r_type.funct7 == 7'b0000001)
                    && (instr_q.r_type.funct3 inside {3'b000, 3'b011, 3'b101, 3'b111});

  assign rf_raddr_a_o = instr_q.i_type.rs1;
  assign rf_raddr_b_o = instr_q.r_type.rs2;
  assign addi_sum     = rf_rdata_a_i + imm_i;

  always_comb begin
    case (instr_q.r_type.funct3)
      3'b011:  acc_qop_o = mempool_cc_pkg::MULHU;
      3'b101:  acc_qop_o = mempool_cc_pkg::DIVU;
      3'b111:  acc_qop_o = mempool_cc_pkg::REMU;
      default: acc_qop_o = mempool_cc_pkg::MUL;
    endcase
  end

  // Request payloads hold still, the register file does not change while waiting
  assign acc_qid_o     = instr_q.r_type.rd;
  assign acc_qarga_o   = rf_rdata_a_i;
  assign acc_qargb_o   = rf_rdata_b_i;
  assign acc_qvalid_o  = (state_q == StWaitAcc) && !req_done_q;
  assign acc_pready_o  = (state_q == StWaitAcc);

  assign data_qaddr_o  = rf_rdata_a_i + (is_store ? imm_s : imm_i);
  assign data_qwrite_o = is_store;
  assign data_qdata_o  = rf_rdata_b_i;
  assign data_qvalid_o = (state_q == StWaitTcdm) && !req_done_q;
  assign data_pready_o = 1'b1;

  assign inst_addr_o  = pc_q;
  assign inst_valid_o = (state_q == StFetch);

  // --------------------
  // Sequencing
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle:     state_d = StFetch;
      StFetch:    if (inst_ready_i) state_d = StDecode;
      StDecode: begin
        if (is_load || is_store) state_d = StWaitTcdm;
        else if (is_mdu)         state_d = StWaitAcc;
        else                     state_d = StExec;
      end
      StExec:     state_d = StFetch;
      StWaitAcc:  if (acc_pvalid_i) state_d = StFetch;
      StWaitTcdm: if (data_pvalid_i) state_d = StFetch;
      default:    state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= StIdle;
      pc_q       <= '0;
      req_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (inst_valid_o && inst_ready_i) begin
        pc_q <= pc_q + `MCC_XLEN'd4;
      end
      if (state_q == StDecode) begin
        req_done_q <= 1'b0;
      end else if ((acc_qvalid_o && acc_qready_i) || (data_qvalid_o && data_qready_i)) begin
        req_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (inst_valid_o && inst_ready_i) begin
      instr_q <= inst_data_i;
    end
  end

  // Writeback source select, stores write nothing
  always_comb begin
    rf_we_o    = 1'b0;
    rf_waddr_o = instr_q.i_type.rd;
    rf_wdata_o = addi_sum;
    case (state_q)
      StExec:     rf_we_o = is_addi;
      StWaitAcc: begin
        rf_we_o    = acc_pvalid_i;
        rf_waddr_o = acc_pid_i;
        rf_wdata_o = acc_pdata_i;
      end
      StWaitTcdm: begin
        rf_we_o    = data_pvalid_i & is_load;
        rf_wdata_o = data_pdata_i;
      end
      default: ;
    endcase
  end

endmodule

// ==== rtl/mempool_ipu.sv ====
/*
  Integer processing unit: two-stage multiplier and a bit-serial
  unsigned restoring divider behind one offload request/response port
*/
`timescale 1ns/1ps
`include "mempool_cc_consts.svh"

module mempool_ipu (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  mempool_cc_pkg::ipu_op_e qop_i,
  input  logic [`MCC_ID_W-1:0]   qid_i,
  input  logic [`MCC_XLEN-1:0]   qarga_i,
  input  logic [`MCC_XLEN-1:0]   qargb_i,
  input  logic                   qvalid_i,
  output logic                   qready_o,
  output logic [`MCC_XLEN-1:0]   pdata_o,
  output logic [`MCC_ID_W-1:0]   pid_o,
  output logic                   pvalid_o,
  input  logic                   pready_i
);

  logic                      busy_q, pvalid_q;
  logic [5:0]                cnt_q;
  mempool_cc_pkg::ipu_op_e   op_q;
  logic [`MCC_ID_W-1:0]      id_q;
  logic [2*`MCC_XLEN-1:0]    prod_q;
  logic [`MCC_XLEN-1:0]      quo_q, rem_q, dvs_q, res_q;
  logic [`MCC_XLEN:0]        rem_shift, diff;
  logic [`MCC_XLEN-1:0]      quo_next, rem_next;
  logic                      req_fire, rsp_fire, q_is_div, op_is_div, last;

  assign req_fire  = qvalid_i & qready_o;
  assign rsp_fire  = pvalid_q & pready_i;
  assign q_is_div  = (qop_i == mempool_cc_pkg::DIVU) || (qop_i == mempool_cc_pkg::REMU);
  assign op_is_div = (op_q == mempool_cc_pkg::DIVU) || (op_q == mempool_cc_pkg::REMU);
  assign last      = busy_q && (cnt_q == 6'd1);

  // --------------------
  // Divider step
  // --------------------
  // A zero divisor never borrows: quotient all ones, remainder the dividend
  assign rem_shift = {rem_q, quo_q[`MCC_XLEN-1]};
  assign diff      = rem_shift - {1'b0, dvs_q};
  assign rem_next  = diff[`MCC_XLEN] ? rem_shift[`MCC_XLEN-1:0] : diff[`MCC_XLEN-1:0];
  assign quo_next  = {quo_q[`MCC_XLEN-2:0], ~diff[`MCC_XLEN]};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_q   <= 1'b0;
      pvalid_q <= 1'b0;
      cnt_q    <= '0;
    end else begin
      if (req_fire) begin
        busy_q <= 1'b1;
        cnt_q  <= q_is_div ? 6'd32 : 6'd1;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 6'd1;
        if (last) begin
          busy_q   <= 1'b0;
          pvalid_q <= 1'b1;
        end
      end
      if (rsp_fire) begin
        pvalid_q <= 1'b0;
      end
    end
  end

  // Operands and results
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q   <= qop_i;
      id_q   <= qid_i;
      prod_q <= {{`MCC_XLEN{1'b0}}, qarga_i} * {{`MCC_XLEN{1'b0}}, qargb_i};
      quo_q  <= qarga_i;
      dvs_q  <= qargb_i;
      rem_q  <= '0;
    end else if (busy_q && op_is_div) begin
      quo_q <= quo_next;
      rem_q <= rem_next;
    end
    if (last) begin
      case (op_q)
        mempool_cc_pkg::MULHU: res_q <= prod_q[2*`MCC_XLEN-1:`MCC_XLEN];
        mempool_cc_pkg::DIVU:  res_q <= quo_next;
        mempool_cc_pkg::REMU:  res_q <= rem_next;
        default:               res_q <= prod_q[`MCC_XLEN-1:0];
      endcase
    end
  end

  // One operation at a time, including its pending response
  assign qready_o = ~busy_q & ~pvalid_q;
  assign pvalid_o = pvalid_q;
  assign pdata_o  = res_q;
  assign pid_o    = id_q;

endmodule

// ==== rtl/mempool_regfile.sv ====
/*
  32 x 32 register file, two combinational read ports, one write port
*/
`timescale 1ns/1ps
`include "mempool_cc_consts.svh"

module mempool_regfile (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [4:0]           raddr_a_i,
  input  logic [4:0]           raddr_b_i,
  output logic [`MCC_XLEN-1:0] rdata_a_o,
  output logic [`MCC_XLEN-1:0] rdata_b_o,
  input  logic [4:0]           waddr_i,
  input  logic [`MCC_XLEN-1:0] wdata_i,
  input  logic                 we_i
);

  // x0 has no storage
  logic [`MCC_XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == 5'd0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== rtl/mempool_spill_register.sv ====
/*
  Two-slot valid/ready cut register, optionally bypassed
*/
`timescale 1ns/1ps

module mempool_spill_register #(
  parameter bit Bypass = 1'b0,
  parameter int Width  = 32
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic             a_full_q, b_full_q;
    logic [Width-1:0] a_data_q, b_data_q;
    logic             a_fill, a_drain, b_fill, b_drain;

    // Slot A takes new input, slot B holds the older word on a stall
    assign a_fill  = valid_i & ready_o;
    assign a_drain = a_full_q & ~b_full_q;
    assign b_fill  = a_drain & ~ready_i;
    assign b_drain = b_full_q & ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Ready only looks at the local slots
    assign ready_o = ~a_full_q | ~b_full_q;
    assign valid_o = a_full_q | b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run into sim.log, then search the log for the failure line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module mempool_cc_tb -o mempool_cc_sim \
  && ./obj_dir/mempool_cc_sim > sim.log 2>&1 \
  || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// ==== sim.f ====
+incdir+include
rtl/mempool_cc_pkg.sv
rtl/mempool_spill_register.sv
rtl/mempool_regfile.sv
rtl/mempool_ipu.sv
rtl/mempool_core_ctrl.sv
rtl/mempool_cc.sv
bench/mempool_cc_props.sv
bench/mempool_cc_tb.sv
